// ==== floo_pkg.sv ====
`default_nettype none

package floo_pkg;

  // Transaction ID
  localparam int unsigned IdWidth = 2;
  localparam int unsigned NumIds = 1 << IdWidth;

  // Destination of a request in the network
  localparam int unsigned DestWidth = 2;

  // Burst length, number of beats minus one
  localparam int unsigned LenWidth = 2;

  // Response payload
  localparam int unsigned DataWidth = 32;

  // Reorder buffer geometry
  localparam int unsigned RobSize = 8;
  localparam int unsigned RobIdxWidth = $clog2(RobSize);

  // Outstanding transactions per ID when no reorder buffer is used
  localparam int unsigned MaxTxnsPerId = 3;
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  // Response ordering scheme of one path
  typedef enum logic {
    SimpleRob = 1'b0,
    NoRob     = 1'b1
  } rob_type_e;

endpackage

`default_nettype wire

// ==== floo_id_counters.sv ====
`timescale 1ns/100ps
`default_nettype none

module floo_id_counters (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [floo_pkg::IdWidth-1:0]    lookup_id_i,
  output logic [floo_pkg::DestWidth-1:0]  lookup_dest_o,
  output logic                            lookup_busy_o,
  output logic                            lookup_full_o,
  input  logic                            push_i,
  input  logic [floo_pkg::IdWidth-1:0]    push_id_i,
  input  logic [floo_pkg::DestWidth-1:0]  push_dest_i,
  input  logic                            pop_i,
  input  logic [floo_pkg::IdWidth-1:0]    pop_id_i
);

  logic [floo_pkg::CntWidth-1:0]  cnt_q  [floo_pkg::NumIds];
  logic [floo_pkg::DestWidth-1:0] dest_q [floo_pkg::NumIds];

  logic [floo_pkg::NumIds-1:0]    inc;
  logic [floo_pkg::NumIds-1:0]    dec;

  // One-hot increment and decrement per ID
  always_comb begin
    inc = '0;
    dec = '0;
    inc[push_id_i] = push_i;
    dec[pop_id_i]  = pop_i;
  end

  // Outstanding count per ID, push and pop together cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < floo_pkg::NumIds; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < floo_pkg::NumIds; i++) begin
        if (inc[i] && !dec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (dec[i] && !inc[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // Destination of the transactions in flight on each ID
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      dest_q[push_id_i] <= push_dest_i;
    end
  end

  assign lookup_busy_o = (cnt_q[lookup_id_i] != '0);
  assign lookup_full_o = (cnt_q[lookup_id_i] == floo_pkg::CntWidth'(floo_pkg::MaxTxnsPerId));
  assign lookup_dest_o = dest_q[lookup_id_i];

endmodule

`default_nettype wire

// ==== floo_simple_rob.sv ====
`timescale 1ns/100ps
`default_nettype none

module floo_simple_rob (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              alloc_i,
  input  logic [floo_pkg::LenWidth-1:0]     alloc_len_i,
  output logic                              alloc_space_o,
  output logic [floo_pkg::RobIdxWidth-1:0]  alloc_idx_o,
  input  logic                              beat_valid_i,
  input  logic [floo_pkg::RobIdxWidth-1:0]  beat_idx_i,
  input  logic [floo_pkg::DataWidth-1:0]    beat_data_i,
  input  logic [floo_pkg::IdWidth-1:0]      beat_id_i,
  input  logic                              beat_last_i,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic [floo_pkg::DataWidth-1:0]    out_data_o,
  output logic [floo_pkg::IdWidth-1:0]      out_id_o,
  output logic                              out_last_o
);

  // Slot storage
  logic [floo_pkg::DataWidth-1:0]   slot_data_q [floo_pkg::RobSize];
  logic [floo_pkg::IdWidth-1:0]     slot_id_q   [floo_pkg::RobSize];
  logic                             slot_last_q [floo_pkg::RobSize];
  logic [floo_pkg::RobSize-1:0]     filled_q;

  // Circular allocation state
  logic [floo_pkg::RobIdxWidth-1:0] head_q;
  logic [floo_pkg::RobIdxWidth-1:0] tail_q;
  logic [floo_pkg::RobIdxWidth:0]   free_q;
  logic [floo_pkg::RobIdxWidth:0]   alloc_num;
  logic [floo_pkg::RobIdxWidth:0]   alloc_dec;

  // Output stage
  logic                             out_valid_q;
  logic [floo_pkg::DataWidth-1:0]   out_data_q;
  logic [floo_pkg::IdWidth-1:0]     out_id_q;
  logic                             out_last_q;
  logic                             accept;
  logic                             load;
  logic [floo_pkg::RobIdxWidth-1:0] load_idx;

  // A burst of L+1 beats takes L+1 slots
  assign alloc_num     = (floo_pkg::RobIdxWidth + 1)'(alloc_len_i) + 1'b1;
  assign alloc_dec     = alloc_i ? alloc_num : '0;
  assign alloc_space_o = (free_q >= alloc_num);
  assign alloc_idx_o   = tail_q;

  assign accept   = out_valid_q && out_ready_i;
  assign load     = !out_valid_q || out_ready_i;
  // Next slot to present, one past head once the current beat leaves
  assign load_idx = accept ? head_q + 1'b1 : head_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_q      <= '0;
      tail_q      <= '0;
      free_q      <= (floo_pkg::RobIdxWidth + 1)'(floo_pkg::RobSize);
      filled_q    <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (alloc_i) begin
        tail_q <= tail_q + alloc_num[floo_pkg::RobIdxWidth-1:0];
      end
      if (accept) begin
        head_q <= head_q + 1'b1;
      end
      free_q <= free_q - alloc_dec + {{floo_pkg::RobIdxWidth{1'b0}}, accept};
      // Slot being written is never the head slot being freed
      if (beat_valid_i) begin
        filled_q[beat_idx_i] <= 1'b1;
      end
      if (accept) begin
        filled_q[head_q] <= 1'b0;
      end
      if (load) begin
        out_valid_q <= filled_q[load_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      slot_data_q[beat_idx_i] <= beat_data_i;
      slot_id_q[beat_idx_i]   <= beat_id_i;
      slot_last_q[beat_idx_i] <= beat_last_i;
    end
    if (load) begin
      out_data_q <= slot_data_q[load_idx];
      out_id_q   <= slot_id_q[load_idx];
      out_last_q <= slot_last_q[load_idx];
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;
  assign out_id_o    = out_id_q;
  assign out_last_o  = out_last_q;

endmodule

`default_nettype wire

// ==== floo_rob_wrapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module floo_rob_wrapper #(
  parameter floo_pkg::rob_type_e RobType = floo_pkg::SimpleRob
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              ax_valid_i,
  output logic                              ax_ready_o,
  input  logic [floo_pkg::LenWidth-1:0]     ax_len_i,
  input  logic [floo_pkg::IdWidth-1:0]      ax_id_i,
  input  logic [floo_pkg::DestWidth-1:0]    ax_dest_i,
  output logic                              ax_valid_o,
  input  logic                              ax_ready_i,
  output logic [floo_pkg::RobIdxWidth-1:0]  ax_rob_idx_o,
  input  logic                              rsp_valid_i,
  output logic                              rsp_ready_o,
  input  logic [floo_pkg::DataWidth-1:0]    rsp_data_i,
  input  logic [floo_pkg::IdWidth-1:0]      rsp_id_i,
  input  logic [floo_pkg::RobIdxWidth-1:0]  rsp_rob_idx_i,
  input  logic                              rsp_last_i,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output logic [floo_pkg::DataWidth-1:0]    rsp_data_o,
  output logic [floo_pkg::IdWidth-1:0]      rsp_id_o,
  output logic                              rsp_last_o
);

  if (RobType == floo_pkg::SimpleRob) begin : gen_simple_rob
    logic admit;

    // Every expected beat owns a slot, so responses are never stalled
    assign rsp_ready_o = 1'b1;
    assign ax_valid_o  = ax_valid_i && admit;
    assign ax_ready_o  = ax_ready_i && admit;

    floo_simple_rob u_rob (
      .clk_i         ( clk_i                                 ),
      .reset_i       ( reset_i                               ),
      .alloc_i       ( ax_valid_i && admit && ax_ready_i     ),
      .alloc_len_i   ( ax_len_i                              ),
      .alloc_space_o ( admit                                 ),
      .alloc_idx_o   ( ax_rob_idx_o                          ),
      .beat_valid_i  ( rsp_valid_i                           ),
      .beat_idx_i    ( rsp_rob_idx_i                         ),
      .beat_data_i   ( rsp_data_i                            ),
      .beat_id_i     ( rsp_id_i                              ),
      .beat_last_i   ( rsp_last_i                            ),
      .out_valid_o   ( rsp_valid_o                           ),
      .out_ready_i   ( rsp_ready_i                           ),
      .out_data_o    ( rsp_data_o                            ),
      .out_id_o      ( rsp_id_o                              ),
      .out_last_o    ( rsp_last_o                            )
    );
  end else begin : gen_no_rob
    logic                           busy;
    logic                           full;
    logic                           admit;
    logic [floo_pkg::DestWidth-1:0] prev_dest;

    // Same ID may only follow its predecessors to the same destination
    assign admit = !busy || (ax_dest_i == prev_dest && !full);

    assign ax_valid_o   = ax_valid_i && admit;
    assign ax_ready_o   = ax_ready_i && admit;
    assign ax_rob_idx_o = '0;

    assign rsp_valid_o = rsp_valid_i;
    assign rsp_ready_o = rsp_ready_i;
    assign rsp_data_o  = rsp_data_i;
    assign rsp_id_o    = rsp_id_i;
    assign rsp_last_o  = rsp_last_i;

    floo_id_counters u_id_counters (
      .clk_i         ( clk_i                                     ),
      .reset_i       ( reset_i                                   ),
      .lookup_id_i   ( ax_id_i                                   ),
      .lookup_dest_o ( prev_dest                                 ),
      .lookup_busy_o ( busy                                      ),
      .lookup_full_o ( full                                      ),
      .push_i        ( ax_valid_i && admit && ax_ready_i         ),
      .push_id_i     ( ax_id_i                                   ),
      .push_dest_i   ( ax_dest_i                                 ),
      .pop_i         ( rsp_valid_i && rsp_ready_i && rsp_last_i  ),
      .pop_id_i      ( rsp_id_i                                  )
    );
  end

endmodule

`default_nettype wire

// ==== floo_rob_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module floo_rob_unit (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // Read requests
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [floo_pkg::LenWidth-1:0]     ar_len_i,
  input  logic [floo_pkg::IdWidth-1:0]      ar_id_i,
  input  logic [floo_pkg::DestWidth-1:0]    ar_dest_i,
  output logic                              ar_valid_o,
  input  logic                              ar_ready_i,
  output logic [floo_pkg::RobIdxWidth-1:0]  ar_rob_idx_o,
  // Read responses
  input  logic                              r_valid_i,
  output logic                              r_ready_o,
  input  logic [floo_pkg::DataWidth-1:0]    r_data_i,
  input  logic [floo_pkg::IdWidth-1:0]      r_id_i,
  input  logic [floo_pkg::RobIdxWidth-1:0]  r_rob_idx_i,
  input  logic                              r_last_i,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [floo_pkg::DataWidth-1:0]    r_data_o,
  output logic [floo_pkg::IdWidth-1:0]      r_id_o,
  output logic                              r_last_o,
  // Write requests
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [floo_pkg::LenWidth-1:0]     aw_len_i,
  input  logic [floo_pkg::IdWidth-1:0]      aw_id_i,
  input  logic [floo_pkg::DestWidth-1:0]    aw_dest_i,
  output logic                              aw_valid_o,
  input  logic                              aw_ready_i,
  // Write responses
  input  logic                              b_valid_i,
  output logic                              b_ready_o,
  input  logic [floo_pkg::IdWidth-1:0]      b_id_i,
  input  logic                              b_last_i,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output logic [floo_pkg::IdWidth-1:0]      b_id_o,
  output logic                              b_last_o
);

  floo_rob_wrapper #(
    .RobType ( floo_pkg::SimpleRob )
  ) u_rd_rob (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .ax_valid_i    ( ar_valid_i   ),
    .ax_ready_o    ( ar_ready_o   ),
    .ax_len_i      ( ar_len_i     ),
    .ax_id_i       ( ar_id_i      ),
    .ax_dest_i     ( ar_dest_i    ),
    .ax_valid_o    ( ar_valid_o   ),
    .ax_ready_i    ( ar_ready_i   ),
    .ax_rob_idx_o  ( ar_rob_idx_o ),
    .rsp_valid_i   ( r_valid_i    ),
    .rsp_ready_o   ( r_ready_o    ),
    .rsp_data_i    ( r_data_i     ),
    .rsp_id_i      ( r_id_i       ),
    .rsp_rob_idx_i ( r_rob_idx_i  ),
    .rsp_last_i    ( r_last_i     ),
    .rsp_valid_o   ( r_valid_o    ),
    .rsp_ready_i   ( r_ready_i    ),
    .rsp_data_o    ( r_data_o     ),
    .rsp_id_o      ( r_id_o       ),
    .rsp_last_o    ( r_last_o     )
  );

  // B carries no payload and needs no slot index
  floo_rob_wrapper #(
    .RobType ( floo_pkg::NoRob )
  ) u_wr_rob (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .ax_valid_i    ( aw_valid_i   ),
    .ax_ready_o    ( aw_ready_o   ),
    .ax_len_i      ( aw_len_i     ),
    .ax_id_i       ( aw_id_i      ),
    .ax_dest_i     ( aw_dest_i    ),
    .ax_valid_o    ( aw_valid_o   ),
    .ax_ready_i    ( aw_ready_i   ),
    .ax_rob_idx_o  (              ),
    .rsp_valid_i   ( b_valid_i    ),
    .rsp_ready_o   ( b_ready_o    ),
    .rsp_data_i    (              ),
    .rsp_id_i      ( b_id_i       ),
    .rsp_rob_idx_i (              ),
    .rsp_last_i    ( b_last_i     ),
    .rsp_valid_o   ( b_valid_o    ),
    .rsp_ready_i   ( b_ready_i    ),
    .rsp_data_o    (              ),
    .rsp_id_o      ( b_id_o       ),
    .rsp_last_o    ( b_last_o     )
  );

endmodule

`default_nettype wire

// ==== tb_floo_rob_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_floo_rob_unit;

  // All six tests together take a few hundred cycles
  localparam int MaxCycles = 2000;

  logic                              clk_i = 1'b0;
  logic                              reset_i;
  logic                              ar_valid_i, ar_ready_o, ar_valid_o, ar_ready_i;
  logic [floo_pkg::LenWidth-1:0]     ar_len_i, aw_len_i;
  logic [floo_pkg::IdWidth-1:0]      ar_id_i, r_id_i, r_id_o, aw_id_i, b_id_i, b_id_o;
  logic [floo_pkg::DestWidth-1:0]    ar_dest_i, aw_dest_i;
  logic [floo_pkg::RobIdxWidth-1:0]  ar_rob_idx_o, r_rob_idx_i;
  logic                              r_valid_i, r_ready_o, r_last_i;
  logic                              r_valid_o, r_ready_i, r_last_o;
  logic [floo_pkg::DataWidth-1:0]    r_data_i, r_data_o;
  logic                              aw_valid_i, aw_ready_o, aw_valid_o, aw_ready_i;
  logic                              b_valid_i, b_ready_o, b_last_i;
  logic                              b_valid_o, b_ready_i, b_last_o;

  integer      seed = 32'h5f644b79;
  int          cycles = 0;
  int          test_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  // Model of the slot allocation, filled as requests are issued
  logic [2:0]  exp_tail = '0;
  logic [31:0] slot_data [8];
  logic [1:0]  slot_id   [8];
  logic        slot_last [8];
  // Entries are {last, id, data}
  logic [34:0] exp_q [$];
  logic [34:0] got_q [$];

  floo_rob_unit u_floo_rob_unit (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Test failed");
      $finish;
    end
  end

  // Record every R beat that the next rising edge accepts
  always @(negedge clk_i) begin
    #5;
    if (!reset_i && r_valid_o && r_ready_i) begin
      got_q.push_back({r_last_o, r_id_o, r_data_o});
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("[ERROR] %s = %h, expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: %0d check(s) failed", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic reserve_slots(input logic [1:0] len, input logic [1:0] id);
    logic [2:0] slot;
    for (int k = 0; k <= int'(len); k++) begin
      slot            = exp_tail + 3'(k);
      slot_data[slot] = $random(seed);
      slot_id[slot]   = id;
      slot_last[slot] = (k == int'(len));
      exp_q.push_back({slot_last[slot], id, slot_data[slot]});
    end
    exp_tail = exp_tail + 3'(len) + 3'd1;
  endtask

  task automatic issue_read(input logic [1:0] len, input logic [1:0] id);
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_len_i   = len;
    ar_id_i    = id;
    ar_dest_i  = id;
    #5;
    expect_true(ar_valid_o && ar_ready_o, "Read request not admitted although slots were free");
    check_value("ar_rob_idx_o", 32'(ar_rob_idx_o), 32'(exp_tail));
    reserve_slots(len, id);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic return_beat(input logic [2:0] slot);
    @(negedge clk_i);
    r_valid_i   = 1'b1;
    r_rob_idx_i = slot;
    r_data_i    = slot_data[slot];
    r_id_i      = slot_id[slot];
    r_last_i    = slot_last[slot];
    #5;
    expect_true(r_ready_o, "R beat with a reserved slot was not accepted");
  endtask

  task automatic stop_beats();
    @(negedge clk_i);
    r_valid_i = 1'b0;
  endtask

  // Compare everything released so far with the allocation order
  task automatic check_drain();
    int          n;
    int          waited;
    logic [34:0] exp;
    logic [34:0] got;
    n      = exp_q.size();
    waited = 0;
    while (got_q.size() < n && waited < 100) begin
      @(negedge clk_i);
      waited++;
    end
    repeat (2) @(negedge clk_i);
    expect_true(got_q.size() == n, "Number of released R beats differs from beats returned");
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      exp = exp_q.pop_front();
      got = got_q.pop_front();
      check_value("r_data_o", got[31:0], exp[31:0]);
      check_value("r_id_o", 32'(got[33:32]), 32'(exp[33:32]));
      check_value("r_last_o", 32'(got[34]), 32'(exp[34]));
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic send_aw(input logic [1:0] id, input logic [1:0] dest, input logic pass);
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_dest_i  = dest;
    #5;
    if (pass) begin
      expect_true(aw_valid_o && aw_ready_o, "Write request blocked although its ID allows it");
    end else begin
      expect_true(!aw_valid_o && !aw_ready_o, "Write request passed although its ID forbids it");
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic send_b(input logic [1:0] id);
    @(negedge clk_i);
    b_valid_i = 1'b1;
    b_id_i    = id;
    b_last_i  = 1'b1;
    b_ready_i = 1'b1;
    #5;
    check_value("b_valid_o", 32'(b_valid_o), 32'd1);
    check_value("b_ready_o", 32'(b_ready_o), 32'd1);
    check_value("b_id_o", 32'(b_id_o), 32'(id));
    check_value("b_last_o", 32'(b_last_o), 32'd1);
    @(negedge clk_i);
    b_valid_i = 1'b0;
  endtask

  task automatic test_in_order_reads();
    for (int i = 0; i < 4; i++) begin
      issue_read(2'd0, 2'(i));
    end
    for (int i = 0; i < 4; i++) begin
      return_beat(3'(i));
    end
    stop_beats();
    check_drain();
    finish_test("in-order reads");
  endtask

  task automatic test_reverse_reads();
    logic [2:0] base;
    base = exp_tail;
    for (int i = 0; i < 4; i++) begin
      issue_read(2'd0, 2'(3 - i));
    end
    for (int i = 3; i >= 0; i--) begin
      return_beat(base + 3'(i));
    end
    stop_beats();
    check_drain();
    finish_test("out-of-order reads");
  endtask

  task automatic test_bursts();
    logic [2:0] base;
    base = exp_tail;
    issue_read(2'd2, 2'd1);
    issue_read(2'd1, 2'd2);
    // Beats of both bursts interleaved
    return_beat(base + 3'd3);
    return_beat(base + 3'd1);
    return_beat(base + 3'd4);
    return_beat(base + 3'd0);
    return_beat(base + 3'd2);
    stop_beats();
    check_drain();
    finish_test("bursts");
  endtask

  task automatic test_full_buffer();
    logic [2:0]  base;
    logic [31:0] held;
    logic [34:0] head;
    int          waited;
    base = exp_tail;
    // Seven of eight slots taken, a two-beat read must wait
    issue_read(2'd3, 2'd0);
    issue_read(2'd2, 2'd3);
    @(negedge clk_i);
    r_ready_i  = 1'b0;
    ar_valid_i = 1'b1;
    ar_len_i   = 2'd1;
    ar_id_i    = 2'd2;
    ar_dest_i  = 2'd1;
    #5;
    expect_true(!ar_valid_o && !ar_ready_o, "Read request admitted into a full buffer");
    for (int k = 0; k < 7; k++) begin
      return_beat(base + 3'(6 - k));
      expect_true(!ar_valid_o && !ar_ready_o, "Read request admitted into a full buffer");
    end
    stop_beats();
    waited = 0;
    while (!r_valid_o && waited < 20) begin
      @(negedge clk_i);
      #5;
      waited++;
    end
    expect_true(r_valid_o, "No R beat presented while the head slot was filled");
    head = exp_q[0];
    held = r_data_o;
    check_value("r_data_o", held, head[31:0]);
    repeat (4) begin
      @(negedge clk_i);
      #5;
      expect_true(r_valid_o, "r_valid_o dropped before the beat was accepted");
      check_value("r_data_o", r_data_o, held);
      expect_true(!ar_valid_o && !ar_ready_o, "Read request admitted into a full buffer");
    end
    @(negedge clk_i);
    r_ready_i = 1'b1;
    #5;
    waited = 0;
    while (!(ar_valid_o && ar_ready_o) && waited < 20) begin
      @(negedge clk_i);
      #5;
      waited++;
    end
    expect_true(ar_valid_o && ar_ready_o, "Waiting read request never admitted after draining");
    check_value("ar_rob_idx_o", 32'(ar_rob_idx_o), 32'(exp_tail));
    base = exp_tail;
    reserve_slots(2'd1, 2'd2);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    return_beat(base + 3'd1);
    return_beat(base);
    stop_beats();
    check_drain();
    finish_test("full buffer and back-pressure");
  endtask

  task automatic test_write_ordering();
    send_aw(2'd1, 2'd0, 1'b1);
    send_aw(2'd1, 2'd2, 1'b0);
    send_aw(2'd1, 2'd0, 1'b1);
    send_b(2'd1);
    send_b(2'd1);
    send_aw(2'd1, 2'd2, 1'b1);
    send_b(2'd1);
    finish_test("write ordering");
  endtask

  task automatic test_counter_limit();
    int waited;
    repeat (floo_pkg::MaxTxnsPerId) send_aw(2'd2, 2'd3, 1'b1);
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_id_i    = 2'd2;
    aw_dest_i  = 2'd3;
    #5;
    expect_true(!aw_valid_o && !aw_ready_o, "Write request passed with its ID count full");
    // B offered but held by the endpoint, the count must not drop yet
    @(negedge clk_i);
    b_valid_i = 1'b1;
    b_id_i    = 2'd2;
    b_last_i  = 1'b1;
    b_ready_i = 1'b0;
    #5;
    check_value("b_valid_o", 32'(b_valid_o), 32'd1);
    check_value("b_ready_o", 32'(b_ready_o), 32'd0);
    check_value("b_id_o", 32'(b_id_o), 32'd2);
    check_value("b_last_o", 32'(b_last_o), 32'd1);
    expect_true(!aw_valid_o && !aw_ready_o, "Write request passed before a B was accepted");
    @(negedge clk_i);
    b_ready_i = 1'b1;
    #5;
    check_value("b_ready_o", 32'(b_ready_o), 32'd1);
    @(negedge clk_i);
    b_valid_i = 1'b0;
    #5;
    waited = 0;
    while (!(aw_valid_o && aw_ready_o) && waited < 10) begin
      @(negedge clk_i);
      #5;
      waited++;
    end
    expect_true(aw_valid_o && aw_ready_o, "Write request still blocked after its B was accepted");
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    finish_test("counter limit");
  endtask

  initial begin
    reset_i     = 1'b1;
    ar_valid_i  = 1'b0;
    ar_len_i    = '0;
    ar_id_i     = '0;
    ar_dest_i   = '0;
    ar_ready_i  = 1'b1;
    r_valid_i   = 1'b0;
    r_data_i    = '0;
    r_id_i      = '0;
    r_rob_idx_i = '0;
    r_last_i    = 1'b0;
    r_ready_i   = 1'b1;
    aw_valid_i  = 1'b0;
    aw_len_i    = '0;
    aw_id_i     = '0;
    aw_dest_i   = '0;
    aw_ready_i  = 1'b1;
    b_valid_i   = 1'b0;
    b_id_i      = '0;
    b_last_i    = 1'b0;
    b_ready_i   = 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_in_order_reads();
    test_reverse_reads();
    test_bursts();
    test_full_buffer();
    test_write_ordering();
    test_counter_limit();

    $display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
floo_pkg.sv
floo_id_counters.sv
floo_simple_rob.sv
floo_rob_wrapper.sv
floo_rob_unit.sv
tb_floo_rob_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f \
  --top-module tb_floo_rob_unit -o tb_floo_rob_unit

./obj_dir/tb_floo_rob_unit | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
